// ==== src/pic_pkg.sv ====
package pic_pkg;

	// ==============================
	// sizes
	// ==============================
	// source 0 is the non-maskable line
	localparam int NUM_SRC = 32;
	localparam int SRC_W = 5;
	localparam int LEVEL_W = 4;
	localparam int CAUSE_W = 8;
	localparam int CORE_W = 6;
	localparam int DATA_W = 32;
	// register word index is the byte address over four
	localparam int IDX_W = 6;

	// field positions inside a control word
	localparam int CTRL_LEVEL_LSB = 8;
	localparam int CTRL_IE_BIT = 16;
	localparam int CTRL_ES_BIT = 17;
	localparam int CTRL_RESP_BIT = 18;
	localparam int CTRL_CORE_LSB = 24;

	// ==============================
	// reset values
	// ==============================
	localparam logic [CAUSE_W-1:0] SPURIOUS_CAUSE = 8'd24;
	localparam logic [LEVEL_W-1:0] RST_LEVEL = 4'd8;
	// everything disabled, edge sensed and answering inta
	localparam logic [NUM_SRC-1:0] RST_IE = '0;
	localparam logic [NUM_SRC-1:0] RST_ES = '1;
	localparam logic [NUM_SRC-1:0] RST_RESP = '1;

	// register word map
	typedef enum logic [IDX_W-1:0] {
		REG_ENC = 6'd0,
		REG_IE = 6'd1,
		REG_IE_CLR = 6'd2,
		REG_IE_SET = 6'd3,
		REG_EDGE = 6'd4,
		REG_EDGE_RST = 6'd5,
		REG_TRIG = 6'd6,
		REG_CTRL_BASE = 6'd32
	} reg_op_e;

	// bus cycle controller states
	typedef enum logic [1:0] {ST_IDLE, ST_ACK, ST_HOLD} bus_state_e;

endpackage

// ==== src/pic_reg_if.sv ====
`timescale 1ns/1ns

interface pic_reg_if;
	import pic_pkg::*;

	// ==============================
	// register access channel
	// ==============================
	// write strobe is high for one cycle only
	logic wr;
	// read strobe is high for one cycle only
	logic rd;
	// word index taken from the byte address
	logic [IDX_W-1:0] idx;
	logic [DATA_W-1:0] wdata;
	// registered read data, valid the cycle after rd
	logic [DATA_W-1:0] rdata;

	// bus controller view
	modport bus
	(
		output wr,
		output rd,
		output idx,
		output wdata,
		input rdata
	);

	// register file view
	modport regs
	(
		input wr,
		input rd,
		input idx,
		input wdata,
		output rdata
	);

endinterface

// ==== src/pic_bus_ctrl.sv ====
`timescale 1ns/1ns

module pic_bus_ctrl
(
	input logic clk,
	input logic rst_i,
	input logic cs_i,
	input logic we_i,
	input logic inta_i,
	input logic [7:0] adr_i,
	input logic [pic_pkg::DATA_W-1:0] dat_i,
	input logic [pic_pkg::SRC_W-1:0] cur_src_i,
	input logic [pic_pkg::NUM_SRC-1:0] resp_inta_i,
	pic_reg_if.bus bus,
	output logic ack_o,
	output logic vp_o,
	output logic inta_o
);
	import pic_pkg::*;

	bus_state_e state_q;
	bus_state_e state_d;
	logic strobe;
	logic idle;

	// either kind of cycle holds the controller busy
	assign strobe = cs_i | inta_i;
	assign idle = (state_q == ST_IDLE);

	// ==============================
	// register strobes
	// ==============================
	// strobes only leave idle, so each lasts one cycle
	assign bus.wr = idle & cs_i & we_i;
	// chip select wins if both strobes show up together
	assign bus.rd = idle & ((cs_i & ~we_i) | (inta_i & ~cs_i));
	assign inta_o = idle & inta_i & ~cs_i;
	assign bus.idx = adr_i[IDX_W+1:2];
	assign bus.wdata = dat_i;

	// ==============================
	// cycle state machine
	// ==============================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				if (strobe)
					state_d = ST_ACK;
			end
			ST_ACK:
			begin
				// a strobe still held must not be acked again
				if (strobe)
					state_d = ST_HOLD;
				else
					state_d = ST_IDLE;
			end
			ST_HOLD:
			begin
				if (!strobe)
					state_d = ST_IDLE;
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= ST_IDLE;
			vp_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// vector pull when the winner does not answer inta
			vp_o <= inta_o & ~resp_inta_i[cur_src_i];
		end
	end

	// ack lines up with the registered read data
	assign ack_o = (state_q == ST_ACK);

endmodule

// ==== src/pic_regs.sv ====
`timescale 1ns/1ns

module pic_regs
(
	input logic clk,
	input logic rst_i,
	pic_reg_if.regs regs,
	input logic inta_i,
	input logic [pic_pkg::LEVEL_W-1:0] ack_level_i,
	input logic [pic_pkg::SRC_W-1:0] cur_src_i,
	output logic [pic_pkg::NUM_SRC-1:0] ie_o,
	output logic [pic_pkg::NUM_SRC-1:0] es_o,
	output logic [pic_pkg::NUM_SRC-1:0] trig_o,
	output logic [pic_pkg::NUM_SRC-1:0] rste_o,
	output logic [pic_pkg::NUM_SRC-1:0] resp_inta_o,
	output logic [pic_pkg::LEVEL_W-1:0] level_o [pic_pkg::NUM_SRC],
	output logic [pic_pkg::CAUSE_W-1:0] cause_o [pic_pkg::NUM_SRC],
	output logic [pic_pkg::CORE_W-1:0] core_o [pic_pkg::NUM_SRC]
);
	import pic_pkg::*;

	logic [SRC_W-1:0] sel;
	logic [SRC_W-1:0] ctrl_src;
	logic is_ctrl;
	logic [DATA_W-1:0] rd_word;

	// single-source ops pick the source from the low data bits
	assign sel = regs.wdata[SRC_W-1:0];
	// upper half of the map is one control word per source
	assign is_ctrl = (regs.idx >= REG_CTRL_BASE);
	assign ctrl_src = regs.idx[SRC_W-1:0];

	// ==============================
	// register writes
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ie_o <= RST_IE;
			es_o <= RST_ES;
			resp_inta_o <= RST_RESP;
			trig_o <= '0;
			rste_o <= '0;
			for (int n = 0; n < NUM_SRC; n++)
			begin
				level_o[n] <= RST_LEVEL;
				cause_o[n] <= '0;
				core_o[n] <= '0;
			end
		end
		else
		begin
			// trigger and edge reset are one-cycle pulses
			trig_o <= '0;
			rste_o <= '0;
			if (regs.wr)
			begin
				if (is_ctrl)
				begin
					cause_o[ctrl_src] <= regs.wdata[CAUSE_W-1:0];
					level_o[ctrl_src] <= regs.wdata[CTRL_LEVEL_LSB +: LEVEL_W];
					ie_o[ctrl_src] <= regs.wdata[CTRL_IE_BIT];
					es_o[ctrl_src] <= regs.wdata[CTRL_ES_BIT];
					resp_inta_o[ctrl_src] <= regs.wdata[CTRL_RESP_BIT];
					core_o[ctrl_src] <= regs.wdata[CTRL_CORE_LSB +: CORE_W];
				end
				else
				begin
					case (regs.idx)
						REG_IE: ie_o <= regs.wdata;
						REG_IE_CLR: ie_o[sel] <= 1'b0;
						REG_IE_SET: ie_o[sel] <= 1'b1;
						REG_EDGE: es_o <= regs.wdata;
						REG_EDGE_RST: rste_o[sel] <= 1'b1;
						REG_TRIG: trig_o[sel] <= 1'b1;
						// the encoder word is read only
						default: ;
					endcase
				end
			end
		end
	end

	// ==============================
	// read data select
	// ==============================
	always_comb
	begin
		rd_word = '0;
		if (inta_i)
		begin
			// a non-responding source leaves the word at zero
			if (resp_inta_o[cur_src_i])
			begin
				// asked level above the source level is spurious
				if (ack_level_i > level_o[cur_src_i])
					rd_word[CAUSE_W-1:0] = SPURIOUS_CAUSE;
				else
					rd_word[CAUSE_W-1:0] = cause_o[cur_src_i];
			end
		end
		else if (is_ctrl)
		begin
			rd_word[CTRL_ES_BIT] = es_o[ctrl_src];
			rd_word[CTRL_IE_BIT] = ie_o[ctrl_src];
			rd_word[CTRL_LEVEL_LSB +: LEVEL_W] = level_o[ctrl_src];
			rd_word[CAUSE_W-1:0] = cause_o[ctrl_src];
		end
		else if (regs.idx == REG_ENC)
			rd_word[CAUSE_W-1:0] = cause_o[cur_src_i];
		else
			rd_word = ie_o;
	end

	// data only shows in the cycle after rd, zero otherwise
	always_ff @(posedge clk)
	begin
		if (rst_i)
			regs.rdata <= '0;
		else if (regs.rd)
			regs.rdata <= rd_word;
		else
			regs.rdata <= '0;
	end

endmodule

// ==== src/pic_edge_detect.sv ====
`timescale 1ns/1ns

module pic_edge_detect
(
	input logic clk,
	input logic rst_i,
	input logic [pic_pkg::NUM_SRC-1:0] irq_i,
	input logic [pic_pkg::NUM_SRC-1:0] es_i,
	input logic [pic_pkg::NUM_SRC-1:0] trig_i,
	input logic [pic_pkg::NUM_SRC-1:0] rste_i,
	output logic [pic_pkg::NUM_SRC-1:0] pending_o
);
	import pic_pkg::*;

	// sampled request lines
	logic [NUM_SRC-1:0] irq_q;
	// latched rising edges
	logic [NUM_SRC-1:0] edge_q;
	logic [NUM_SRC-1:0] rise;

	// line high now but low at the last edge
	assign rise = irq_i & ~irq_q;

	// ==============================
	// input sampling and edge latch
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			irq_q <= '0;
			edge_q <= '0;
		end
		else
		begin
			irq_q <= irq_i;
			// clear beats a set arriving in the same cycle
			edge_q <= (edge_q | rise | trig_i) & ~rste_i;
		end
	end

	// edge-sensed sources use the latch, level-sensed the sampled line
	assign pending_o = (edge_q & es_i) | (irq_q & ~es_i);

endmodule

// ==== src/pic_prio_enc.sv ====
`timescale 1ns/1ns

module pic_prio_enc
(
	input logic clk,
	input logic rst_i,
	input logic [pic_pkg::NUM_SRC-1:0] pending_i,
	input logic [pic_pkg::NUM_SRC-1:0] ie_i,
	input logic [pic_pkg::LEVEL_W-1:0] level_i [pic_pkg::NUM_SRC],
	input logic [pic_pkg::CAUSE_W-1:0] cause_i [pic_pkg::NUM_SRC],
	input logic [pic_pkg::CORE_W-1:0] core_i [pic_pkg::NUM_SRC],
	input logic nmi_i,
	output logic [pic_pkg::SRC_W-1:0] cur_src_o,
	output logic [pic_pkg::LEVEL_W-1:0] irq_level_o,
	output logic [pic_pkg::CAUSE_W-1:0] cause_o,
	output logic [pic_pkg::CORE_W-1:0] core_o,
	output logic nmi_o
);
	import pic_pkg::*;

	logic [SRC_W-1:0] win;

	// ==============================
	// lowest pending source wins
	// ==============================
	// scan downwards so the lowest number is written last
	// source 0 is the nmi and never gets encoded
	always_comb
	begin
		win = '0;
		for (int n = NUM_SRC - 1; n > 0; n--)
		begin
			if (pending_i[n])
				win = SRC_W'(n);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cur_src_o <= '0;
			irq_level_o <= '0;
			cause_o <= '0;
			core_o <= '0;
			nmi_o <= 1'b0;
		end
		else
		begin
			cur_src_o <= win;
			// nmi bypasses the encoder, gated by enable bit 0
			nmi_o <= nmi_i & ie_i[0];
			if (cur_src_o == '0)
			begin
				irq_level_o <= '0;
				cause_o <= '0;
				core_o <= '0;
			end
			else
			begin
				// disabled winner keeps its cause but drops its level
				irq_level_o <= ie_i[cur_src_o] ? level_i[cur_src_o] : '0;
				cause_o <= cause_i[cur_src_o];
				core_o <= core_i[cur_src_o];
			end
		end
	end

endmodule

// ==== src/pic_top.sv ====
`timescale 1ns/1ns

module pic_top
(
	input logic clk,
	input logic rst_i,
	input logic cs_i,
	input logic we_i,
	input logic inta_i,
	input logic [7:0] adr_i,
	input logic [pic_pkg::DATA_W-1:0] dat_i,
	output logic [pic_pkg::DATA_W-1:0] dat_o,
	output logic ack_o,
	output logic vp_o,
	input logic [pic_pkg::NUM_SRC-2:0] irq_i,
	input logic nmi_i,
	output logic [pic_pkg::LEVEL_W-1:0] irq_level_o,
	output logic [pic_pkg::CAUSE_W-1:0] cause_o,
	output logic [pic_pkg::CORE_W-1:0] core_o,
	output logic nmi_o
);
	import pic_pkg::*;

	// ==============================
	// internal nets
	// ==============================
	logic [NUM_SRC-1:0] src;
	logic [NUM_SRC-1:0] ie;
	logic [NUM_SRC-1:0] es;
	logic [NUM_SRC-1:0] trig_pulse;
	logic [NUM_SRC-1:0] rste_pulse;
	logic [NUM_SRC-1:0] resp_inta;
	logic [NUM_SRC-1:0] pending;
	logic [LEVEL_W-1:0] level [NUM_SRC];
	logic [CAUSE_W-1:0] cause [NUM_SRC];
	logic [CORE_W-1:0] core [NUM_SRC];
	logic [SRC_W-1:0] cur_src;
	logic [LEVEL_W-1:0] ack_level;
	logic inta_rd;

	// nmi sits in bit 0 of the source word
	assign src = {irq_i, nmi_i};
	// inta cycles carry the level in address bits 3 to 1
	assign ack_level = {1'b0, adr_i[3:1]};
	// register file zeroes rdata outside the ack cycle
	assign dat_o = reg_bus.rdata;

	pic_reg_if reg_bus ();

	pic_bus_ctrl u_bus_ctrl (
		.clk(clk), .rst_i(rst_i),
		.cs_i(cs_i), .we_i(we_i), .inta_i(inta_i),
		.adr_i(adr_i), .dat_i(dat_i),
		.cur_src_i(cur_src), .resp_inta_i(resp_inta),
		.bus(reg_bus),
		.ack_o(ack_o), .vp_o(vp_o), .inta_o(inta_rd)
	);

	pic_regs u_regs (
		.clk(clk), .rst_i(rst_i), .regs(reg_bus),
		.inta_i(inta_rd), .ack_level_i(ack_level), .cur_src_i(cur_src),
		.ie_o(ie), .es_o(es), .trig_o(trig_pulse), .rste_o(rste_pulse),
		.resp_inta_o(resp_inta),
		.level_o(level), .cause_o(cause), .core_o(core)
	);

	pic_edge_detect u_edge (
		.clk(clk), .rst_i(rst_i), .irq_i(src),
		.es_i(es), .trig_i(trig_pulse), .rste_i(rste_pulse),
		.pending_o(pending)
	);

	pic_prio_enc u_prio (
		.clk(clk), .rst_i(rst_i),
		.pending_i(pending), .ie_i(ie),
		.level_i(level), .cause_i(cause), .core_i(core),
		.nmi_i(nmi_i), .cur_src_o(cur_src),
		.irq_level_o(irq_level_o), .cause_o(cause_o), .core_o(core_o),
		.nmi_o(nmi_o)
	);

endmodule

// ==== dv/pic_assert.sv ====
`timescale 1ns/1ns

module pic_assert
(
	input logic clk,
	input logic rst_i,
	input logic ack_o,
	input logic vp_o,
	input logic nmi_i,
	input logic nmi_o
);

	// ==============================
	// bus handshake
	// ==============================
	// a cycle is acked once, ST_ACK never repeats back to back
	ack_single: assert property (@(posedge clk) disable iff (rst_i) ack_o |=> !ack_o)
		else $error("ack_o high two cycles in a row");

	// outputs are cleared by the first reset edge
	ack_reset: assert property (@(posedge clk) $past(rst_i) |-> (!ack_o && !vp_o))
		else $error("ack_o or vp_o high during reset");

	// vector pull only ends an acknowledge cycle
	vp_with_ack: assert property (@(posedge clk) disable iff (rst_i) vp_o |-> ack_o)
		else $error("vp_o high without ack_o");

	// ==============================
	// nmi path
	// ==============================
	// nmi_o is nmi_i gated and delayed by one register
	nmi_follow: assert property (@(posedge clk) disable iff (rst_i) nmi_o |-> $past(nmi_i))
		else $error("nmi_o high without nmi_i one cycle earlier");

endmodule

bind pic_top pic_assert u_assert (
	.clk(clk), .rst_i(rst_i), .ack_o(ack_o), .vp_o(vp_o),
	.nmi_i(nmi_i), .nmi_o(nmi_o)
);

// ==== dv/pic_tb.sv ====
`timescale 1ns/1ns

module pic_tb;
	import pic_pkg::*;

	// about 700 bus cycles of ~4 clocks plus ~300 settle waits of 4 clocks
	// stay far below this
	localparam int CYCLE_LIMIT = 20000;
	localparam int ACK_LIMIT = 10;

	logic clk;
	logic rst_i;
	logic cs_i;
	logic we_i;
	logic inta_i;
	logic [7:0] adr_i;
	logic [DATA_W-1:0] dat_i;
	logic [DATA_W-1:0] dat_o;
	logic ack_o;
	logic vp_o;
	logic [NUM_SRC-2:0] irq_i;
	logic nmi_i;
	logic [LEVEL_W-1:0] irq_level_o;
	logic [CAUSE_W-1:0] cause_o;
	logic [CORE_W-1:0] core_o;
	logic nmi_o;

	integer seed;
	int cycles = 0;

	// ==============================
	// reference model state
	// ==============================
	logic [NUM_SRC-1:0] m_ie;
	logic [NUM_SRC-1:0] m_es;
	logic [NUM_SRC-1:0] m_latch;
	logic [NUM_SRC-1:0] m_resp;
	// source word as driven, nmi in bit 0
	logic [NUM_SRC-1:0] m_src;
	logic [LEVEL_W-1:0] m_level [NUM_SRC];
	logic [CAUSE_W-1:0] m_cause [NUM_SRC];
	logic [CORE_W-1:0] m_core [NUM_SRC];

	pic_top DUT (
		.clk(clk), .rst_i(rst_i), .cs_i(cs_i), .we_i(we_i), .inta_i(inta_i),
		.adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o), .vp_o(vp_o),
		.irq_i(irq_i), .nmi_i(nmi_i), .irq_level_o(irq_level_o),
		.cause_o(cause_o), .core_o(core_o), .nmi_o(nmi_o)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run did not end within %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_outputs(input string name, input logic [LEVEL_W-1:0] exp_level,
		input logic [CAUSE_W-1:0] exp_cause, input logic [CORE_W-1:0] exp_core);
		if (irq_level_o !== exp_level || cause_o !== exp_cause || core_o !== exp_core)
		begin
			$display("ERR %s: expected level %h cause %h core %h, actual level %h cause %h core %h",
				name, exp_level, exp_cause, exp_core, irq_level_o, cause_o, core_o);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	// ==============================
	// bus tasks
	// ==============================
	// strobe is already driven, step a cycle at a time until ack
	task automatic wait_ack();
		int n;
		n = 0;
		while (ack_o !== 1'b1)
		begin
			if (n == ACK_LIMIT)
			begin
				$display("no ack_o within %0d cycles of the bus strobe", ACK_LIMIT);
				stop_run();
			end
			@(posedge clk);
			#5;
			n++;
		end
	endtask

	task automatic reg_write(input logic [IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
		@(posedge clk);
		#5;
		cs_i = 1'b1;
		we_i = 1'b1;
		adr_i = {idx, 2'b00};
		dat_i = data;
		wait_ack();
		cs_i = 1'b0;
		we_i = 1'b0;
	endtask

	task automatic reg_read(input logic [IDX_W-1:0] idx, output logic [DATA_W-1:0] data);
		@(posedge clk);
		#5;
		cs_i = 1'b1;
		adr_i = {idx, 2'b00};
		wait_ack();
		data = dat_o;
		cs_i = 1'b0;
	endtask

	// acknowledge cycle, level sits on address bits 3 to 1
	task automatic inta_cycle(input logic [2:0] lvl, output logic [DATA_W-1:0] data,
		output logic vp);
		@(posedge clk);
		#5;
		inta_i = 1'b1;
		adr_i = {4'b0000, lvl, 1'b0};
		wait_ack();
		data = dat_o;
		vp = vp_o;
		inta_i = 1'b0;
	endtask

	task automatic set_sources(input logic [NUM_SRC-1:0] w);
		@(posedge clk);
		#5;
		irq_i = w[NUM_SRC-1:1];
		nmi_i = w[0];
		// every rising line is latched, whatever its sense
		m_latch = m_latch | (w & ~m_src);
		m_src = w;
	endtask

	// request path is three edges deep, sample after the fourth
	task automatic settle();
		repeat (4) @(posedge clk);
		#5;
	endtask

	// model update follows the control word layout
	task automatic ctrl_write(input int n, input logic [DATA_W-1:0] data);
		m_cause[n] = data[7:0];
		m_level[n] = data[11:8];
		m_ie[n] = data[16];
		m_es[n] = data[17];
		m_resp[n] = data[18];
		m_core[n] = data[29:24];
		reg_write(REG_CTRL_BASE + IDX_W'(n), data);
	endtask

	task automatic clear_latches();
		for (int n = 0; n < NUM_SRC; n++)
			reg_write(REG_EDGE_RST, DATA_W'(n));
		m_latch = '0;
	endtask

	// ==============================
	// reference model
	// ==============================
	function automatic logic [DATA_W-1:0] next_random();
		return $random(seed);
	endfunction

	function automatic int pick_src();
		logic [DATA_W-1:0] r;
		r = next_random();
		return (r[4:0] == 5'd0) ? 31 : int'(r[4:0]);
	endfunction

	// first pending source counting up from 1, zero if none
	function automatic int model_winner();
		logic [NUM_SRC-1:0] pend;
		int w;
		pend = (m_latch & m_es) | (m_src & ~m_es);
		w = 1;
		while (w < NUM_SRC && !pend[w])
			w++;
		return (w == NUM_SRC) ? 0 : w;
	endfunction

	// read layout: edge 17, enable 16, level 11..8, cause 7..0
	function automatic logic [DATA_W-1:0] ctrl_read(input int n);
		logic [DATA_W-1:0] w;
		w = '0;
		w[17] = m_es[n];
		w[16] = m_ie[n];
		w[11:8] = m_level[n];
		w[7:0] = m_cause[n];
		return w;
	endfunction

	task automatic check_irq(input string name);
		int w;
		w = model_winner();
		if (w == 0)
			check_outputs(name, '0, '0, '0);
		else
			check_outputs(name, m_ie[w] ? m_level[w] : '0, m_cause[w], m_core[w]);
	endtask

	initial
	begin
		logic [DATA_W-1:0] r;
		logic [DATA_W-1:0] sel;
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] src_w;
		logic [LEVEL_W-1:0] lvl;
		logic [CAUSE_W-1:0] exp_cause;
		logic vp;
		int n;
		int w;

		seed = 32'h8ec636f2;
		rst_i = 1'b1;
		cs_i = 1'b0;
		we_i = 1'b0;
		inta_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		irq_i = '0;
		nmi_i = 1'b0;
		m_ie = '0;
		m_es = '1;
		m_latch = '0;
		m_resp = '1;
		m_src = '0;
		for (int i = 0; i < NUM_SRC; i++)
		begin
			m_level[i] = RST_LEVEL;
			m_cause[i] = '0;
			m_core[i] = '0;
		end
		repeat (4) @(posedge clk);
		#5;
		rst_i = 1'b0;
		check_outputs("reset outputs", '0, '0, '0);
		check_flag("reset ack", 1'b0, ack_o);
		check_flag("reset vp", 1'b0, vp_o);
		check_flag("reset nmi", 1'b0, nmi_o);

		// ==============================
		// register readback
		// ==============================
		for (int i = 0; i < 60; i++)
		begin
			sel = next_random();
			r = next_random();
			n = int'(sel[4:0]);
			if (sel[6:5] == 2'd0)
			begin
				m_ie = r;
				reg_write(REG_IE, r);
				reg_read(REG_IE, rd);
				check_data("enable word readback", m_ie, rd);
			end
			else if (sel[6:5] == 2'd1)
			begin
				// edge word is only visible through the control words
				m_es = r;
				reg_write(REG_EDGE, r);
				reg_read(REG_CTRL_BASE + IDX_W'(n), rd);
				check_data("edge select readback", ctrl_read(n), rd);
			end
			else
			begin
				ctrl_write(n, r);
				reg_read(REG_CTRL_BASE + IDX_W'(n), rd);
				check_data("control word readback", ctrl_read(n), rd);
			end
		end

		// single enable set and clear, upper data bits are noise
		for (int i = 0; i < 40; i++)
		begin
			r = next_random();
			n = int'(r[4:0]);
			m_ie[n] = r[8];
			if (r[8])
				reg_write(REG_IE_SET, r);
			else
				reg_write(REG_IE_CLR, r);
			reg_read(REG_IE, rd);
			check_data("single enable", m_ie, rd);
		end

		// ==============================
		// level sensed requests
		// ==============================
		m_es = '0;
		reg_write(REG_EDGE, '0);
		for (int i = 0; i < 60; i++)
		begin
			// sparse patterns so the winner moves around
			r = next_random() & next_random() & next_random();
			r[0] = 1'b0;
			if (i % 8 == 0)
				r = '0;
			set_sources(r);
			settle();
			check_irq("level sensed winner");
			reg_read(REG_ENC, rd);
			check_data("encoder read", DATA_W'(m_cause[model_winner()]), rd);
		end

		// ==============================
		// edge latches and trigger
		// ==============================
		set_sources('0);
		m_es = '1;
		reg_write(REG_EDGE, '1);
		clear_latches();
		for (int i = 0; i < 80; i++)
		begin
			r = next_random();
			n = pick_src();
			if (r[9:8] == 2'd0)
			begin
				src_w = m_src;
				src_w[n] = 1'b1;
				set_sources(src_w);
				settle();
				check_irq("edge latched");
				src_w[n] = 1'b0;
				set_sources(src_w);
				settle();
				check_irq("edge held after input low");
			end
			else if (r[9:8] == 2'd1)
			begin
				m_latch[n] = 1'b1;
				reg_write(REG_TRIG, DATA_W'(n));
				settle();
				check_irq("software trigger");
			end
			else
			begin
				w = model_winner();
				m_latch[w] = 1'b0;
				reg_write(REG_EDGE_RST, DATA_W'(w));
				settle();
				check_irq("edge reset");
			end
		end

		// ==============================
		// acknowledge cycles
		// ==============================
		clear_latches();
		for (int i = 0; i < 40; i++)
		begin
			r = next_random();
			n = pick_src();
			// keep the source edge sensed
			r[17] = 1'b1;
			ctrl_write(n, r);
			m_latch[n] = 1'b1;
			reg_write(REG_TRIG, DATA_W'(n));
			settle();
			check_irq("triggered winner");
			r = next_random();
			lvl = {1'b0, r[2:0]};
			inta_cycle(lvl[2:0], rd, vp);
			w = model_winner();
			if (m_resp[w])
			begin
				exp_cause = (lvl > m_level[w]) ? SPURIOUS_CAUSE : m_cause[w];
				check_data("inta cause", DATA_W'(exp_cause), rd);
				check_flag("inta no vector pull", 1'b0, vp);
			end
			else
			begin
				check_data("inta non-responding", '0, rd);
				check_flag("inta vector pull", 1'b1, vp);
			end
			m_latch[n] = 1'b0;
			reg_write(REG_EDGE_RST, DATA_W'(n));
		end

		// ==============================
		// nmi gating
		// ==============================
		// a live winner shows that nmi leaves the cause alone
		n = pick_src();
		m_latch[n] = 1'b1;
		reg_write(REG_TRIG, DATA_W'(n));
		for (int i = 0; i < 30; i++)
		begin
			r = next_random();
			m_ie[0] = r[0];
			if (r[0])
				reg_write(REG_IE_SET, '0);
			else
				reg_write(REG_IE_CLR, '0);
			src_w = m_src;
			src_w[0] = r[1];
			set_sources(src_w);
			settle();
			check_flag("nmi gated by enable 0", r[1] & m_ie[0], nmi_o);
			check_irq("nmi leaves cause");
		end

		$display("Test OK");
		$finish;
	end

endmodule

// ==== project.f ====
src/pic_pkg.sv
src/pic_reg_if.sv
src/pic_bus_ctrl.sv
src/pic_regs.sv
src/pic_edge_detect.sv
src/pic_prio_enc.sv
src/pic_top.sv
dv/pic_assert.sv
dv/pic_tb.sv

// ==== Makefile ====
# Verilator build and run for the interrupt controller testbench

VERILATOR ?= verilator
TOP ?= pic_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the binary is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
